// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // page select on top, register offset below.
  localparam int page_bits   = 20;
  localparam int offset_bits = $bits(addr_t) - page_bits;

  typedef logic [offset_bits-1:0] offset_t;

  // ##################################################
  // default page bases and block widths
  localparam addr_t default_gpio_base  = 32'h1000_2000;
  localparam addr_t default_timer_base = 32'h1000_3000;

  localparam int default_led_width   = 16;
  localparam int default_digit_count = 8;

  // ##################################################
  // register offsets
  localparam offset_t gpio_led_offset    = 12'h000;
  localparam offset_t gpio_switch_offset = 12'h004;  // read-only.
  localparam offset_t gpio_seg_offset    = 12'h008;

  localparam offset_t timer_ctrl_offset    = 12'h000;  // bit 0 enables.
  localparam offset_t timer_count_offset   = 12'h004;  // read-only.
  localparam offset_t timer_compare_offset = 12'h008;
  localparam offset_t timer_status_offset  = 12'h00C;  // bit 0 match, write 1 to clear.

  // segments a..g in bits 7:1, decimal point in bit 0.
  typedef logic [7:0] seg_t;

endpackage

`default_nettype wire

// File: seg7_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_encoder (
  input  logic [3:0]       digit,
  output periph_pkg::seg_t seg
);

  import periph_pkg::*;

  seg_t glyph;  // active high, a..g then dp.

  always_comb begin
    case (digit)
      4'h0:    glyph = 8'b1111_1100;
      4'h1:    glyph = 8'b0110_0000;
      4'h2:    glyph = 8'b1101_1010;
      4'h3:    glyph = 8'b1111_0010;
      4'h4:    glyph = 8'b0110_0110;
      4'h5:    glyph = 8'b1011_0110;
      4'h6:    glyph = 8'b1011_1110;
      4'h7:    glyph = 8'b1110_0000;
      4'h8:    glyph = 8'b1111_1110;
      4'h9:    glyph = 8'b1111_0110;
      4'hA:    glyph = 8'b1110_1110;
      4'hB:    glyph = 8'b0011_1110;  // lower case b.
      4'hC:    glyph = 8'b1001_1100;
      4'hD:    glyph = 8'b0111_1010;  // lower case d.
      4'hE:    glyph = 8'b1001_1110;
      default: glyph = 8'b1000_1110;  // F.
    endcase
  end

  // the display is common anode, so a lit segment is driven low.
  assign seg = ~glyph;

endmodule

`default_nettype wire

// File: apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder #(
  parameter periph_pkg::addr_t gpio_base  = periph_pkg::default_gpio_base,
  parameter periph_pkg::addr_t timer_base = periph_pkg::default_timer_base
) (
  input  periph_pkg::addr_t paddr,
  input  logic              psel,
  input  logic              penable,

  output logic              gpio_psel,
  output logic              timer_psel,

  input  periph_pkg::data_t gpio_rdata,
  input  logic              gpio_slverr,
  input  periph_pkg::data_t timer_rdata,
  input  logic              timer_slverr,

  output periph_pkg::data_t prdata,
  output logic              pslverr
);

  import periph_pkg::*;

  localparam int addr_bits = $bits(addr_t);

  logic gpio_hit;
  logic timer_hit;

  // ##################################################
  // page match on the upper address bits
  assign gpio_hit  = (paddr[addr_bits-1 -: page_bits] == gpio_base[addr_bits-1 -: page_bits]);
  assign timer_hit = (paddr[addr_bits-1 -: page_bits] == timer_base[addr_bits-1 -: page_bits]);

  // gpio wins if both bases ever land on one page.
  assign gpio_psel  = psel & gpio_hit;
  assign timer_psel = psel & timer_hit & ~gpio_hit;

  // ##################################################
  // response mux
  always_comb begin
    if (gpio_hit) begin
      prdata  = gpio_rdata;
      pslverr = gpio_slverr;
    end else if (timer_hit) begin
      prdata  = timer_rdata;
      pslverr = timer_slverr;
    end else begin
      prdata  = '0;
      pslverr = psel & penable;  // unmapped page.
    end
  end

endmodule

`default_nettype wire

// File: gpio_apb.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_apb #(
  parameter int led_width   = periph_pkg::default_led_width,
  parameter int digit_count = periph_pkg::default_digit_count
) (
  input  logic                                clock,
  input  logic                                reset,

  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  periph_pkg::offset_t                 paddr,
  input  periph_pkg::data_t                   pwdata,
  input  periph_pkg::strb_t                   pstrb,
  output periph_pkg::data_t                   rdata,
  output logic                                slverr,

  input  logic [led_width-1:0]                gpio_in,
  output logic [led_width-1:0]                gpio_out,
  output periph_pkg::seg_t [digit_count-1:0]  gpio_seg
);

  import periph_pkg::*;

  localparam int seg_bits = 4 * digit_count;

  logic [led_width-1:0] led;
  logic [led_width-1:0] switch_q;
  logic [seg_bits-1:0]  segment;
  data_t                byte_mask;
  logic                 access;
  logic                 known;
  logic                 bad_write;
  logic                 led_wr;
  logic                 seg_wr;

  always_comb begin
    for (int i = 0; i < $bits(strb_t); i++) begin
      byte_mask[8*i +: 8] = {8{pstrb[i]}};
    end
  end

  // ##################################################
  // access decode
  assign access    = psel & penable;
  assign known     = (paddr == gpio_led_offset) | (paddr == gpio_switch_offset) |
                     (paddr == gpio_seg_offset);
  assign bad_write = pwrite & (paddr == gpio_switch_offset);
  assign slverr    = access & (~known | bad_write);

  assign led_wr = access & pwrite & (paddr == gpio_led_offset);
  assign seg_wr = access & pwrite & (paddr == gpio_seg_offset);

  always_ff @(posedge clock) begin
    if (reset) begin
      led      <= '0;
      segment  <= '0;
      switch_q <= '0;
    end else begin
      switch_q <= gpio_in;  // one sample stage, no debounce.
      if (led_wr) begin
        led <= (led & ~byte_mask[led_width-1:0]) |
               (pwdata[led_width-1:0] & byte_mask[led_width-1:0]);
      end
      if (seg_wr) begin
        segment <= (segment & ~byte_mask[seg_bits-1:0]) |
                   (pwdata[seg_bits-1:0] & byte_mask[seg_bits-1:0]);
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (paddr)
      gpio_led_offset:    rdata[led_width-1:0] = led;
      gpio_switch_offset: rdata[led_width-1:0] = switch_q;
      gpio_seg_offset:    rdata[seg_bits-1:0]  = segment;
      default:            rdata = '0;
    endcase
  end

  assign gpio_out = led;

  // ##################################################
  // one encoder per nibble, digit 0 in the low nibble
  for (genvar i = 0; i < digit_count; i++) begin : g_digit
    seg7_encoder seg7_encoder_i (
      .digit (segment[4*i +: 4]),
      .seg   (gpio_seg[i])
    );
  end

endmodule

`default_nettype wire

// File: apb_timer.sv
`timescale 1ns/1ps
`default_nettype none

module apb_timer (
  input  logic                clock,
  input  logic                reset,

  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  periph_pkg::offset_t paddr,
  input  periph_pkg::data_t   pwdata,
  input  periph_pkg::strb_t   pstrb,
  output periph_pkg::data_t   rdata,
  output logic                slverr,

  output logic                irq
);

  import periph_pkg::*;

  logic  enable;
  data_t count;
  data_t compare;
  logic  status;
  data_t byte_mask;
  logic  access;
  logic  known;
  logic  bad_write;
  logic  match;
  logic  ctrl_wr;
  logic  compare_wr;
  logic  status_clr;

  always_comb begin
    for (int i = 0; i < $bits(strb_t); i++) begin
      byte_mask[8*i +: 8] = {8{pstrb[i]}};
    end
  end

  assign access    = psel & penable;
  assign known     = (paddr == timer_ctrl_offset) | (paddr == timer_count_offset) |
                     (paddr == timer_compare_offset) | (paddr == timer_status_offset);
  assign bad_write = pwrite & (paddr == timer_count_offset);
  assign slverr    = access & (~known | bad_write);

  assign ctrl_wr    = access & pwrite & (paddr == timer_ctrl_offset) & pstrb[0];
  assign compare_wr = access & pwrite & (paddr == timer_compare_offset);
  assign status_clr = access & pwrite & (paddr == timer_status_offset) & pstrb[0] & pwdata[0];

  assign match = enable & (count == compare);

  // ##################################################
  // counter and sticky match flag
  always_ff @(posedge clock) begin
    if (reset) begin
      enable  <= 1'b0;
      count   <= '0;
      compare <= '0;
      status  <= 1'b0;
    end else begin
      if (ctrl_wr) enable <= pwdata[0];
      if (match) count <= '0;
      else if (enable) count <= count + data_t'(1);
      if (compare_wr) compare <= (compare & ~byte_mask) | (pwdata & byte_mask);
      if (match) status <= 1'b1;  // a new match beats a clear in the same cycle.
      else if (status_clr) status <= 1'b0;
    end
  end

  always_comb begin
    rdata = '0;
    case (paddr)
      timer_ctrl_offset:    rdata[0] = enable;
      timer_count_offset:   rdata    = count;
      timer_compare_offset: rdata    = compare;
      timer_status_offset:  rdata[0] = status;
      default:              rdata    = '0;
    endcase
  end

  assign irq = status;

endmodule

`default_nettype wire

// File: periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
  parameter periph_pkg::addr_t gpio_base   = periph_pkg::default_gpio_base,
  parameter periph_pkg::addr_t timer_base  = periph_pkg::default_timer_base,
  parameter int                led_width   = periph_pkg::default_led_width,
  parameter int                digit_count = periph_pkg::default_digit_count
) (
  input  logic                               clock,
  input  logic                               reset,

  input  periph_pkg::addr_t                  paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic [2:0]                         pprot,  // accepted, no protection check.
  input  logic                               pwrite,
  input  periph_pkg::data_t                  pwdata,
  input  periph_pkg::strb_t                  pstrb,
  output logic                               pready,
  output periph_pkg::data_t                  prdata,
  output logic                               pslverr,

  input  logic [led_width-1:0]               gpio_in,
  output logic [led_width-1:0]               gpio_out,
  output periph_pkg::seg_t [digit_count-1:0] gpio_seg,
  output logic                               irq
);

  import periph_pkg::*;

  logic  gpio_psel;
  logic  timer_psel;
  data_t gpio_rdata;
  logic  gpio_slverr;
  data_t timer_rdata;
  logic  timer_slverr;

  assign pready = 1'b1;  // zero wait states.

  // ##################################################
  // bus decode
  apb_decoder #(
    .gpio_base  (gpio_base),
    .timer_base (timer_base)
  ) apb_decoder_i (
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .gpio_psel    (gpio_psel),
    .timer_psel   (timer_psel),
    .gpio_rdata   (gpio_rdata),
    .gpio_slverr  (gpio_slverr),
    .timer_rdata  (timer_rdata),
    .timer_slverr (timer_slverr),
    .prdata       (prdata),
    .pslverr      (pslverr)
  );

  // ##################################################
  // slaves see only the page offset
  gpio_apb #(
    .led_width   (led_width),
    .digit_count (digit_count)
  ) gpio_apb_i (
    .clock    (clock),
    .reset    (reset),
    .psel     (gpio_psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr[offset_bits-1:0]),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .rdata    (gpio_rdata),
    .slverr   (gpio_slverr),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_seg (gpio_seg)
  );

  apb_timer apb_timer_i (
    .clock   (clock),
    .reset   (reset),
    .psel    (timer_psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr[offset_bits-1:0]),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .rdata   (timer_rdata),
    .slverr  (timer_slverr),
    .irq     (irq)
  );

endmodule

`default_nettype wire

// File: periph_chk.sv
`timescale 1ns/1ps
`default_nettype none

module periph_chk (
  input logic clock,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic irq
);

  // ##################################################
  // apb protocol
  pready_high: assert property (@(posedge clock) disable iff (reset) pready)
    else $error("pready low on a zero wait state bus");

  slverr_in_access: assert property (@(posedge clock) disable iff (reset)
    !(psel && penable) |-> !pslverr)
    else $error("pslverr raised outside the access phase");

  // status clears with reset, so irq follows one cycle later.
  irq_after_reset: assert property (@(posedge clock) reset |=> !irq)
    else $error("irq high in the cycle after reset");

endmodule

bind periph_top periph_chk periph_chk_i (
  .clock   (clock),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .irq     (irq)
);

`default_nettype wire

// File: tb_periph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph;

  import periph_pkg::*;

  localparam addr_t gpio_base    = default_gpio_base;
  localparam addr_t timer_base   = default_timer_base;
  localparam int    led_width    = default_led_width;
  localparam int    digit_count  = default_digit_count;
  localparam int    poll_timeout = 40;

  // active-high a..g per hex digit. b and d are lower case.
  localparam logic [6:0] glyphs [16] = '{
    7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011, 7'b1011011,
    7'b1011111, 7'b1110000, 7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
    7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
  };

  logic                   clock;
  logic                   reset;
  addr_t                  paddr;
  logic                   psel;
  logic                   penable;
  logic [2:0]             pprot;
  logic                   pwrite;
  data_t                  pwdata;
  strb_t                  pstrb;
  logic                   pready;
  data_t                  prdata;
  logic                   pslverr;
  logic [led_width-1:0]   gpio_in;
  logic [led_width-1:0]   gpio_out;
  seg_t [digit_count-1:0] gpio_seg;
  logic                   irq;

  int                   errors;
  int                   checks;
  int                   tests_run;
  logic [led_width-1:0] led_model;
  data_t                seg_model;

  periph_top #(
    .gpio_base   (gpio_base),
    .timer_base  (timer_base),
    .led_width   (led_width),
    .digit_count (digit_count)
  ) periph_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ##################################################
  // compare tasks
  task automatic compare_data(input string what, input data_t got, input data_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic compare_seg(input string what, input seg_t got, input seg_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic compare_err(input string what, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  function automatic seg_t expected_seg(input logic [3:0] nibble);
    return ~{glyphs[nibble], 1'b0};  // lit segments low, dp dark.
  endfunction

  function automatic addr_t gpio_reg(input offset_t offset);
    return {gpio_base[$bits(addr_t)-1:offset_bits], offset};
  endfunction

  function automatic addr_t timer_reg(input offset_t offset);
    return {timer_base[$bits(addr_t)-1:offset_bits], offset};
  endfunction

  // ##################################################
  // apb driver
  task automatic apb_transfer(input addr_t addr, input logic write, input data_t wdata,
                              input strb_t strb, output data_t rdata, output logic err);
    int waited;
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    pstrb   <= write ? strb : 4'h0;  // reads carry no strobes.
    psel    <= 1'b1;
    penable <= 1'b0;
    @(negedge clock);
    compare_err("pslverr in setup", pslverr, 1'b0);
    @(posedge clock);
    penable <= 1'b1;
    waited = 0;
    @(negedge clock);
    while (pready !== 1'b1 && waited < poll_timeout) begin
      @(negedge clock);
      waited++;
    end
    if (pready !== 1'b1) begin
      errors++;
      $display("timeout: pready never came for the access to %h", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);  // transfer completes on this edge.
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input data_t data, input strb_t strb,
                           output logic err);
    data_t unused;
    apb_transfer(addr, 1'b1, data, strb, unused, err);
  endtask

  task automatic apb_read(input addr_t addr, output data_t data, output logic err);
    apb_transfer(addr, 1'b0, '0, 4'h0, data, err);
  endtask

  task automatic read_expect(input string what, input addr_t addr, input data_t want);
    data_t rd;
    logic  err;
    apb_read(addr, rd, err);
    compare_data(what, rd, want);
    compare_err({what, " pslverr"}, err, 1'b0);
  endtask

  task automatic write_ok(input string what, input addr_t addr, input data_t data,
                          input strb_t strb);
    logic err;
    apb_write(addr, data, strb, err);
    compare_err(what, err, 1'b0);
  endtask

  task automatic check_digits(input data_t digits);
    @(negedge clock);
    for (int d = 0; d < digit_count; d++) begin
      compare_seg($sformatf("digit %0d", d), gpio_seg[d], expected_seg(digits[4*d +: 4]));
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start) $display("%s: passed", name);
    else $display("%s: %0d failed checks", name, errors - start);
  endtask

  task automatic apply_reset();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
  endtask

  // ##################################################
  // directed tests
  task automatic reset_defaults();
    int start;
    start = errors;
    read_expect("led after reset", gpio_reg(gpio_led_offset), '0);
    read_expect("segments after reset", gpio_reg(gpio_seg_offset), '0);
    read_expect("ctrl after reset", timer_reg(timer_ctrl_offset), '0);
    read_expect("status after reset", timer_reg(timer_status_offset), '0);
    check_digits('0);
    report_test("reset defaults", start);
  endtask

  task automatic led_byte_writes();
    int    start;
    data_t wdata;
    data_t raw;
    start = errors;
    for (int n = 0; n < 8; n++) begin
      wdata = $urandom;
      raw   = $urandom;
      write_ok("led write", gpio_reg(gpio_led_offset), wdata, raw[3:0]);
      for (int b = 0; b < led_width / 8; b++) begin
        if (raw[b]) led_model[8*b +: 8] = wdata[8*b +: 8];
      end
      @(negedge clock);
      compare_data("gpio_out", data_t'(gpio_out), data_t'(led_model));
      read_expect("led readback", gpio_reg(gpio_led_offset), data_t'(led_model));
    end
    report_test("led byte writes", start);
  endtask

  task automatic switch_sampling();
    int    start;
    data_t raw;
    start = errors;
    for (int n = 0; n < 4; n++) begin
      raw = $urandom;
      @(posedge clock);
      gpio_in <= raw[led_width-1:0];
      repeat (2) @(posedge clock);
      read_expect("switches", gpio_reg(gpio_switch_offset), data_t'(raw[led_width-1:0]));
    end
    report_test("switch sampling", start);
  endtask

  task automatic segment_display();
    int start;
    start = errors;
    for (int n = 0; n < 6; n++) begin
      seg_model = $urandom;
      write_ok("segment write", gpio_reg(gpio_seg_offset), seg_model, 4'hF);
      check_digits(seg_model);
      read_expect("segment readback", gpio_reg(gpio_seg_offset), seg_model);
    end
    report_test("segment display", start);
  endtask

  task automatic error_responses();
    int    start;
    data_t rd;
    logic  err;
    start = errors;
    apb_read(32'h1000_5004, rd, err);  // no slave on this page.
    compare_err("unmapped page read", err, 1'b1);
    compare_data("unmapped page data", rd, '0);
    apb_write(gpio_reg(12'h010), $urandom, 4'hF, err);
    compare_err("unknown gpio offset", err, 1'b1);
    apb_write(gpio_reg(gpio_switch_offset), $urandom, 4'hF, err);
    compare_err("switch write", err, 1'b1);
    apb_write(timer_reg(timer_count_offset), $urandom, 4'hF, err);
    compare_err("count write", err, 1'b1);
    read_expect("led kept", gpio_reg(gpio_led_offset), data_t'(led_model));
    read_expect("segments kept", gpio_reg(gpio_seg_offset), seg_model);
    report_test("error responses", start);
  endtask

  task automatic timer_match();
    int    start;
    int    polls;
    data_t limit;
    data_t rd;
    logic  err;
    start = errors;
    limit = 5 + $urandom % 20;
    write_ok("compare write", timer_reg(timer_compare_offset), limit, 4'hF);
    write_ok("timer enable", timer_reg(timer_ctrl_offset), 32'h1, 4'hF);
    polls = 0;
    rd    = '0;
    while (rd[0] !== 1'b1 && polls < poll_timeout) begin
      apb_read(timer_reg(timer_status_offset), rd, err);
      polls++;
    end
    if (rd[0] !== 1'b1) begin
      errors++;
      $display("timeout: timer status never set with compare %0d", limit);
    end
    @(negedge clock);
    compare_err("irq on match", irq, 1'b1);
    write_ok("timer disable", timer_reg(timer_ctrl_offset), 32'h0, 4'hF);
    write_ok("status clear", timer_reg(timer_status_offset), 32'h1, 4'hF);
    read_expect("status after clear", timer_reg(timer_status_offset), '0);
    @(negedge clock);
    compare_err("irq after clear", irq, 1'b0);
    report_test("timer match", start);
  endtask

  initial begin
    void'($urandom(32'h7b17cf65));
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    led_model = '0;
    seg_model = '0;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pprot     = 3'b000;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    gpio_in   = '0;
    apply_reset();
    reset_defaults();
    led_byte_writes();
    switch_sampling();
    segment_display();
    error_responses();
    timer_match();
    $display("tests %0d, checks %0d, failed checks %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
periph_pkg.sv
seg7_encoder.sv
apb_decoder.sv
gpio_apb.sv
apb_timer.sv
periph_top.sv
periph_chk.sv
tb_periph.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_periph
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run $(TOP)"
	@echo "make clean  remove $(BUILD) and $(LOG)"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)
